/* compile.f */
+incdir+verilog
verilog/gpio_pkg.sv
verilog/gpio_regs.sv
verilog/gpio_sampler.sv
verilog/gpio_irq.sv
verilog/gpio.sv
verif/gpio_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the GPIO testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary -f compile.f --top-module gpio_tb -o gpio_sim

# The pipe keeps going on a failing run so the log decides
./obj_dir/gpio_sim 2>&1 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* verif/gpio_tb.sv */
// GPIO controller testbench
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_tb;

    // ==================================================
    // DUT signals
    // ==================================================
    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 eclk = 1'b0;      // Driven by the eclk generator only
    logic                 we;
    logic                 re;
    gpio_pkg::gpio_addr_t addr;
    gpio_pkg::gpio_word_t wdata;
    gpio_pkg::gpio_word_t alt_out;
    gpio_pkg::gpio_word_t pad_in;
    gpio_pkg::gpio_word_t rdata;
    logic                 irq;
    gpio_pkg::gpio_word_t pad_out;
    gpio_pkg::gpio_word_t pad_oe;

    // Shadow of the register map
    gpio_pkg::gpio_word_t sh_out   = '0;
    gpio_pkg::gpio_word_t sh_oe    = '0;
    gpio_pkg::gpio_word_t sh_aux   = '0;
    gpio_pkg::gpio_word_t sh_inte  = '0;
    gpio_pkg::gpio_word_t sh_ptrig = '0;
    gpio_pkg::gpio_word_t sh_in    = '0;    // Expected captured inputs
    gpio_pkg::gpio_word_t sh_ints  = '0;    // Expected sticky status
    gpio_pkg::gpio_ctrl_t sh_ctrl  = '0;

    logic [63:0]          lcg_state     = 64'd67688;
    logic                 eclk_run      = 1'b0;
    logic [2:0]           eclk_cnt      = 3'd0;
    logic                 pads_check_on = 1'b0;
    gpio_pkg::gpio_word_t value;
    gpio_pkg::gpio_word_t mask;

    gpio gpio_i
    (
        .clk     (clk),
        .reset_n (reset_n),
        .eclk    (eclk),
        .we      (we),
        .re      (re),
        .addr    (addr),
        .wdata   (wdata),
        .alt_out (alt_out),
        .pad_in  (pad_in),
        .rdata   (rdata),
        .irq     (irq),
        .pad_out (pad_out),
        .pad_oe  (pad_oe)
    );

    always #10 clk = ~clk;   // 20 ns period

    // Slow edge clock toggling every 6 clk cycles
    always @(posedge clk)
    begin
        if (eclk_run)
        begin
            if (eclk_cnt == 3'd5)
            begin
                eclk     <= ~eclk;
                eclk_cnt <= 3'd0;
            end
            else
                eclk_cnt <= eclk_cnt + 3'd1;
        end
    end

    // ==================================================
    // Reference model
    // ==================================================
    function automatic gpio_pkg::gpio_word_t lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];   // Upper half spreads better
    endfunction

    function automatic gpio_pkg::gpio_word_t ref_read(gpio_pkg::gpio_addr_t a);
        gpio_pkg::gpio_word_t result;
        case (a)
            `GPIO_IN_OFS:    result = sh_in;
            `GPIO_OUT_OFS:   result = sh_out;
            `GPIO_OE_OFS:    result = sh_oe;
            `GPIO_INTE_OFS:  result = sh_inte;
            `GPIO_PTRIG_OFS: result = sh_ptrig;
            `GPIO_AUX_OFS:   result = sh_aux;
            `GPIO_CTRL_OFS:  result = {{(`GPIO_DATA_BITS-`GPIO_CTRL_BITS){1'b0}}, sh_ctrl};
            `GPIO_INTS_OFS:  result = sh_ints;
            default:         result = '0;   // Unmapped
        endcase
        return result;
    endfunction

    function automatic void ref_pads(input gpio_pkg::gpio_word_t alt,
                                     output gpio_pkg::gpio_word_t exp_out,
                                     output gpio_pkg::gpio_word_t exp_oe);
        for (int i = 0; i < `GPIO_DATA_BITS; i++)
        begin
            if (sh_aux[i])
            begin
                exp_out[i] = alt[i];     // Alternate function owns the pin
                exp_oe[i]  = 1'b1;
            end
            else
            begin
                exp_out[i] = sh_out[i];
                exp_oe[i]  = sh_oe[i];
            end
        end
    endfunction

    // Status bits that a change from prev_in to new_in should set
    function automatic gpio_pkg::gpio_word_t ref_edge(gpio_pkg::gpio_word_t prev_in,
                                                      gpio_pkg::gpio_word_t new_in);
        gpio_pkg::gpio_word_t hit;
        hit = '0;
        if (sh_ctrl.irq_enable)
        begin
            for (int i = 0; i < `GPIO_DATA_BITS; i++)
            begin
                if (sh_inte[i] && !sh_oe[i] && prev_in[i] != new_in[i])
                    hit[i] = (new_in[i] == sh_ptrig[i]);   // New level matches trigger
            end
        end
        return hit;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input gpio_pkg::gpio_word_t got,
                              input gpio_pkg::gpio_word_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic check_ctrl(input string name, input gpio_pkg::gpio_ctrl_t got,
                              input gpio_pkg::gpio_ctrl_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: irq is %b, expected %b",
                                        $time, got, exp));
    endtask

    task automatic compare_pads();
        gpio_pkg::gpio_word_t exp_out;
        gpio_pkg::gpio_word_t exp_oe;
        ref_pads(alt_out, exp_out, exp_oe);
        check_word("pad_out", pad_out, exp_out);
        check_word("pad_oe", pad_oe, exp_oe);
    endtask

    // Pads are combinational and compared at every falling edge
    always @(negedge clk)
    begin
        if (pads_check_on)
            compare_pads();
    end

    // ==================================================
    // Bus and wait tasks
    // ==================================================
    task automatic write_reg(input gpio_pkg::gpio_addr_t a, input gpio_pkg::gpio_word_t d);
        @(posedge clk);
        we    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);                         // Write lands on this edge
        we    <= 1'b0;
        case (a)
            `GPIO_OUT_OFS:   sh_out   = d;
            `GPIO_OE_OFS:    sh_oe    = d;
            `GPIO_INTE_OFS:  sh_inte  = d;
            `GPIO_PTRIG_OFS: sh_ptrig = d;
            `GPIO_AUX_OFS:   sh_aux   = d;
            `GPIO_CTRL_OFS:  sh_ctrl  = gpio_pkg::gpio_ctrl_t'(d[`GPIO_CTRL_BITS-1:0]);
            `GPIO_INTS_OFS:  sh_ints  = sh_ints & ~d;   // Write one to clear
            default: ;                                  // IN is read only
        endcase
    endtask

    task automatic read_reg(input gpio_pkg::gpio_addr_t a, output gpio_pkg::gpio_word_t v);
        @(posedge clk);
        re   <= 1'b1;
        addr <= a;
        @(posedge clk);                         // rdata loads here
        re   <= 1'b0;
        @(negedge clk);
        v = rdata;
    endtask

    task automatic check_read(input string name, input gpio_pkg::gpio_addr_t a);
        gpio_pkg::gpio_word_t v;
        read_reg(a, v);
        check_word(name, v, ref_read(a));
    endtask

    task automatic write_and_check(input string name, input gpio_pkg::gpio_addr_t a);
        write_reg(a, lcg_next());
        check_read(name, a);
    endtask

    task automatic wait_eclk(input logic level, input string what);
        int count;
        count = 0;
        @(posedge clk);
        while (eclk !== level && count < 40)
        begin
            @(posedge clk);
            count++;
        end
        if (eclk !== level)
            stop_with_failure({"Timeout: eclk never reached the ", what});
    endtask

    task automatic wait_irq_high();
        int count;
        count = 0;
        while (irq !== 1'b1 && count < 20)
        begin
            @(negedge clk);
            count++;
        end
        if (irq !== 1'b1)
            stop_with_failure("Timeout: irq never went high after the pad change");
    endtask

    // Edge mode capture on the eclk edge chosen by rising
    task automatic run_edge_capture(input logic rising);
        gpio_pkg::gpio_word_t v1;
        gpio_pkg::gpio_word_t v2;
        gpio_pkg::gpio_word_t ctrl_word;
        v1 = lcg_next();
        v2 = lcg_next();
        ctrl_word    = '0;
        ctrl_word[0] = 1'b1;                    // edge_sample
        ctrl_word[1] = rising;                  // sample_rising
        write_reg(`GPIO_CTRL_OFS, ctrl_word);
        wait_eclk(rising, "level after the selected edge");
        wait_eclk(!rising, "level before the selected edge");
        pad_in <= v1;                           // Settles before the edge
        wait_eclk(rising, "selected edge");
        repeat (3) @(posedge clk);              // Past sync and capture
        pad_in <= v2;                           // Must wait for the next edge
        sh_in = v1;
        check_read("rdata IN held", `GPIO_IN_OFS);
        wait_eclk(!rising, "opposite edge");
        wait_eclk(rising, "next selected edge");
        repeat (3) @(posedge clk);
        sh_in = v2;
        check_read("rdata IN next edge", `GPIO_IN_OFS);
    endtask

    // Continuous mode pad change followed by status and irq checks
    task automatic toggle_and_check(input gpio_pkg::gpio_word_t new_in);
        gpio_pkg::gpio_word_t exp_bits;
        exp_bits = ref_edge(sh_in, new_in);
        @(posedge clk);
        pad_in <= new_in;
        sh_in = new_in;
        if (exp_bits != '0)
            wait_irq_high();
        repeat (3) @(posedge clk);
        sh_ints = sh_ints | exp_bits;
        check_read("rdata INTS", `GPIO_INTS_OFS);
        @(negedge clk);
        check_irq(irq, sh_ints != '0);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        reset_n <= 1'b0;
        we      <= 1'b0;
        re      <= 1'b0;
        addr    <= '0;
        wdata   <= '0;
        alt_out <= '0;
        pad_in  <= '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        pads_check_on <= 1'b1;

        // Reset values and register access
        for (int i = 0; i < 8; i++)
            check_read("rdata after reset", gpio_pkg::gpio_addr_t'(i * 4));
        check_irq(irq, 1'b0);
        write_and_check("rdata OUT", `GPIO_OUT_OFS);
        write_and_check("rdata OE", `GPIO_OE_OFS);
        write_and_check("rdata INTE", `GPIO_INTE_OFS);
        write_and_check("rdata PTRIG", `GPIO_PTRIG_OFS);
        write_and_check("rdata AUX", `GPIO_AUX_OFS);
        write_reg(`GPIO_CTRL_OFS, lcg_next());
        read_reg(`GPIO_CTRL_OFS, value);
        check_word("rdata CTRL upper bits", value >> `GPIO_CTRL_BITS, '0);
        check_ctrl("rdata CTRL", gpio_pkg::gpio_ctrl_t'(value[`GPIO_CTRL_BITS-1:0]), sh_ctrl);
        write_reg(`GPIO_IN_OFS, lcg_next());
        check_read("rdata IN after write", `GPIO_IN_OFS);
        check_read("rdata OUT", `GPIO_OUT_OFS);       // Nonzero rdata before each
        check_read("rdata unmapped", 8'h24);
        check_read("rdata OUT", `GPIO_OUT_OFS);
        check_read("rdata unaligned", 8'h07);
        write_reg(`GPIO_CTRL_OFS, '0);

        // Pad drive
        for (int i = 0; i < 8; i++)
        begin
            @(posedge clk);
            alt_out <= lcg_next();
            write_reg(`GPIO_OUT_OFS, lcg_next());
            write_reg(`GPIO_OE_OFS, lcg_next());
            write_reg(`GPIO_AUX_OFS, lcg_next());
            @(negedge clk);
            compare_pads();
        end

        // Continuous sampling
        write_reg(`GPIO_INTE_OFS, '0);
        for (int i = 0; i < 10; i++)
        begin
            value = lcg_next();
            @(posedge clk);
            pad_in <= value;
            repeat (2) @(posedge clk);
            sh_in = value;
            check_read("rdata IN", `GPIO_IN_OFS);
        end

        // Edge clock sampling on rising then falling edges
        eclk_run <= 1'b1;
        run_edge_capture(1'b1);
        run_edge_capture(1'b0);
        eclk_run <= 1'b0;

        // Interrupts with mixed triggers, outputs and enables
        write_reg(`GPIO_CTRL_OFS, '0);
        value = lcg_next();
        @(posedge clk);
        pad_in <= value;
        repeat (3) @(posedge clk);
        sh_in = value;
        write_reg(`GPIO_OE_OFS, lcg_next() & ~32'h0000_00FF);   // Low byte as inputs
        write_reg(`GPIO_PTRIG_OFS, lcg_next());
        write_reg(`GPIO_INTE_OFS, lcg_next() | 32'h0000_00FF);
        write_reg(`GPIO_CTRL_OFS, 32'h0000_0004);               // Global enable
        toggle_and_check(sh_in ^ (lcg_next() | 32'h0000_00FF));
        write_reg(`GPIO_INTS_OFS, '1);
        check_read("rdata INTS cleared", `GPIO_INTS_OFS);
        write_reg(`GPIO_CTRL_OFS, '0);                          // Global enable off
        toggle_and_check(sh_in ^ lcg_next());
        write_reg(`GPIO_CTRL_OFS, 32'h0000_0004);
        write_reg(`GPIO_OE_OFS, '1);                            // All pins driven
        write_reg(`GPIO_INTE_OFS, '1);
        toggle_and_check(~sh_in);

        // Write one to clear
        write_reg(`GPIO_OE_OFS, '0);
        write_reg(`GPIO_PTRIG_OFS, '1);
        toggle_and_check('0);                                   // Only falls so nothing sets
        toggle_and_check(lcg_next() | 32'h0000_000F);
        while (sh_ints != '0)
        begin
            mask = sh_ints & lcg_next();
            if (mask == '0)
                mask = sh_ints & (~sh_ints + 32'd1);            // Lowest set bit
            write_reg(`GPIO_INTS_OFS, mask);
            @(negedge clk);
            check_irq(irq, sh_ints != '0);
            check_read("rdata INTS after clear", `GPIO_INTS_OFS);
        end

        @(negedge clk);
        if (irq === 1'b0)
        begin
            $display("TEST OK");
            $finish;
        end
        else
            stop_with_failure("irq still high at the end of the run");
    end

endmodule

/* verilog/gpio.sv */
// GPIO controller top level
`timescale 1ns/10ps

module gpio
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 eclk,      // External sampling clock
    input  logic                 we,
    input  logic                 re,
    input  gpio_pkg::gpio_addr_t addr,
    input  gpio_pkg::gpio_word_t wdata,
    input  gpio_pkg::gpio_word_t alt_out,   // Alternate function outputs
    input  gpio_pkg::gpio_word_t pad_in,
    output gpio_pkg::gpio_word_t rdata,
    output logic                 irq,
    output gpio_pkg::gpio_word_t pad_out,
    output gpio_pkg::gpio_word_t pad_oe     // Pad driver enable
);

    // ==================================================
    // Internal nets
    // ==================================================
    gpio_pkg::gpio_word_t out_bits;
    gpio_pkg::gpio_word_t oe_bits;
    gpio_pkg::gpio_word_t aux_bits;
    gpio_pkg::gpio_word_t inte_bits;
    gpio_pkg::gpio_word_t ptrig_bits;
    gpio_pkg::gpio_word_t ints_clear;
    gpio_pkg::gpio_word_t ints_bits;
    gpio_pkg::gpio_word_t in_bits;
    gpio_pkg::gpio_ctrl_t ctrl;

    gpio_regs regs_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .we         (we),
        .re         (re),
        .addr       (addr),
        .wdata      (wdata),
        .in_bits    (in_bits),
        .ints_bits  (ints_bits),
        .rdata      (rdata),
        .out_bits   (out_bits),
        .oe_bits    (oe_bits),
        .aux_bits   (aux_bits),
        .inte_bits  (inte_bits),
        .ptrig_bits (ptrig_bits),
        .ints_clear (ints_clear),
        .ctrl       (ctrl)
    );

    gpio_sampler sampler_i
    (
        .clk     (clk),
        .reset_n (reset_n),
        .eclk    (eclk),
        .pad_in  (pad_in),
        .ctrl    (ctrl),
        .in_bits (in_bits)
    );

    gpio_irq irq_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_bits    (in_bits),
        .oe_bits    (oe_bits),
        .inte_bits  (inte_bits),
        .ptrig_bits (ptrig_bits),
        .ints_clear (ints_clear),
        .ctrl       (ctrl),
        .ints_bits  (ints_bits),
        .irq        (irq)
    );

    // ==================================================
    // Pad drive, per pin
    // ==================================================
    assign pad_out = (aux_bits & alt_out) | (~aux_bits & out_bits);   // Aux selects alt source
    assign pad_oe  = aux_bits | oe_bits;   // Alt function always drives

endmodule

/* verilog/gpio_config.svh */
// GPIO configuration constants
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

// ==================================================
// Widths
// ==================================================
`define GPIO_DATA_BITS   32       // Pin count and bus word width
`define GPIO_ADDR_BITS   8        // Local register offset width
`define GPIO_CTRL_BITS   4        // Stored control bits

// ==================================================
// Register offsets
// ==================================================
`define GPIO_IN_OFS      8'h00    // Sampled pad inputs, read only
`define GPIO_OUT_OFS     8'h04    // Output data
`define GPIO_OE_OFS      8'h08    // Output enable, 1 = drive
`define GPIO_INTE_OFS    8'h0C    // Per-pin interrupt enable
`define GPIO_PTRIG_OFS   8'h10    // Trigger, 1 = rising, 0 = falling
`define GPIO_AUX_OFS     8'h14    // Alternate function select
`define GPIO_CTRL_OFS    8'h18    // Sampling mode and global irq enable
`define GPIO_INTS_OFS    8'h1C    // Sticky status, write one to clear

`endif

/* verilog/gpio_irq.sv */
// GPIO interrupt status
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_irq
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  gpio_pkg::gpio_word_t in_bits,     // Sampled inputs
    input  gpio_pkg::gpio_word_t oe_bits,     // Output pins never interrupt
    input  gpio_pkg::gpio_word_t inte_bits,
    input  gpio_pkg::gpio_word_t ptrig_bits,  // 1 = rising, 0 = falling
    input  gpio_pkg::gpio_word_t ints_clear,  // Write-one-to-clear mask
    input  gpio_pkg::gpio_ctrl_t ctrl,
    output gpio_pkg::gpio_word_t ints_bits,   // Sticky status
    output logic                 irq
);

    gpio_pkg::gpio_word_t in_prev;    // Last cycle's sampled inputs
    gpio_pkg::gpio_word_t rise;
    gpio_pkg::gpio_word_t fall;
    gpio_pkg::gpio_word_t event_bits; // Qualified new events

    // ==================================================
    // Per-pin edge detection
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            in_prev <= '0;
        else
            in_prev <= in_bits;
    end

    assign rise = in_bits & ~in_prev & ptrig_bits;    // Rising where trigger set
    assign fall = ~in_bits & in_prev & ~ptrig_bits;   // Falling where trigger clear

    // Enable, global gate and input direction all required
    assign event_bits = (rise | fall) & inte_bits & ~oe_bits
                      & {`GPIO_DATA_BITS{ctrl.irq_enable}};

    // ==================================================
    // Sticky status
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            ints_bits <= '0;
        else
            ints_bits <= (ints_bits & ~ints_clear) | event_bits;   // New event beats clear
    end

    assign irq = |ints_bits;   // Level, high while any bit set

endmodule

/* verilog/gpio_pkg.sv */
// GPIO shared types
`include "gpio_config.svh"

package gpio_pkg;

    // One bit per pin
    typedef logic [`GPIO_DATA_BITS-1:0] gpio_word_t;   // Register, pad and bus data

    // Local offset into the register map
    typedef logic [`GPIO_ADDR_BITS-1:0] gpio_addr_t;

    // ==================================================
    // Control register layout, bit 3 down to bit 0
    // ==================================================
    typedef struct packed {
        logic spare;          // Bit 3, stored only
        logic irq_enable;     // Bit 2, global interrupt gate
        logic sample_rising;  // Bit 1, eclk rising edge when set
        logic edge_sample;    // Bit 0, sample on eclk instead of every clk
    } gpio_ctrl_t;

endpackage

/* verilog/gpio_regs.sv */
// GPIO register file
// Write decode and registered read mux
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_regs
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 we,          // Write strobe
    input  logic                 re,          // Read strobe
    input  gpio_pkg::gpio_addr_t addr,        // Register offset
    input  gpio_pkg::gpio_word_t wdata,
    input  gpio_pkg::gpio_word_t in_bits,     // From sampler
    input  gpio_pkg::gpio_word_t ints_bits,   // From irq block
    output gpio_pkg::gpio_word_t rdata,
    output gpio_pkg::gpio_word_t out_bits,
    output gpio_pkg::gpio_word_t oe_bits,
    output gpio_pkg::gpio_word_t aux_bits,
    output gpio_pkg::gpio_word_t inte_bits,
    output gpio_pkg::gpio_word_t ptrig_bits,
    output gpio_pkg::gpio_word_t ints_clear,  // Clear mask for status
    output gpio_pkg::gpio_ctrl_t ctrl
);

    // ==================================================
    // Write-one-to-clear strobe
    // ==================================================
    logic ints_sel;   // Current offset hits INTS

    assign ints_sel   = (addr == `GPIO_INTS_OFS);
    assign ints_clear = (we && ints_sel) ? wdata : '0;   // Zero outside INTS writes

    // ==================================================
    // Writable registers
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            out_bits   <= '0;
            oe_bits    <= '0;
            aux_bits   <= '0;
            inte_bits  <= '0;
            ptrig_bits <= '0;
            ctrl       <= '0;
        end
        else if (we)
        begin
            case (addr)
                `GPIO_OUT_OFS:   out_bits   <= wdata;
                `GPIO_OE_OFS:    oe_bits    <= wdata;
                `GPIO_AUX_OFS:   aux_bits   <= wdata;
                `GPIO_INTE_OFS:  inte_bits  <= wdata;
                `GPIO_PTRIG_OFS: ptrig_bits <= wdata;
                `GPIO_CTRL_OFS:
                    ctrl <= gpio_pkg::gpio_ctrl_t'(wdata[`GPIO_CTRL_BITS-1:0]);   // Low bits only
                default: ;   // IN and INTS are not stored here
            endcase
        end
    end

    // ==================================================
    // Registered read mux
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            rdata <= '0;
        end
        else
        begin
            case (addr)
                `GPIO_IN_OFS:
                begin
                    if (re)
                        rdata <= in_bits;     // Writes here are ignored
                end
                `GPIO_OUT_OFS:
                begin
                    if (!we && re)
                        rdata <= out_bits;    // Write has priority, rdata holds
                end
                `GPIO_OE_OFS:
                begin
                    if (!we && re)
                        rdata <= oe_bits;
                end
                `GPIO_INTE_OFS:
                begin
                    if (!we && re)
                        rdata <= inte_bits;
                end
                `GPIO_PTRIG_OFS:
                begin
                    if (!we && re)
                        rdata <= ptrig_bits;
                end
                `GPIO_AUX_OFS:
                begin
                    if (!we && re)
                        rdata <= aux_bits;
                end
                `GPIO_CTRL_OFS:
                begin
                    if (!we && re)
                        rdata <= {{(`GPIO_DATA_BITS-`GPIO_CTRL_BITS){1'b0}}, ctrl};
                end
                `GPIO_INTS_OFS:
                begin
                    if (re)
                        rdata <= ints_bits;   // Status before this cycle's clear
                end
                default: rdata <= '0;         // Unmapped offset, every cycle
            endcase
        end
    end

endmodule

/* verilog/gpio_sampler.sv */
// GPIO input sampler
`timescale 1ns/10ps

module gpio_sampler
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 eclk,      // Slow external edge clock
    input  gpio_pkg::gpio_word_t pad_in,    // Raw pad levels
    input  gpio_pkg::gpio_ctrl_t ctrl,
    output gpio_pkg::gpio_word_t in_bits    // Captured inputs
);

    logic eclk_d1;     // First sync stage
    logic eclk_d2;     // Second sync stage
    logic eclk_rise;
    logic eclk_fall;
    logic capture;     // Load pad_in this cycle

    // ==================================================
    // Edge clock synchronizer
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            eclk_d1 <= 1'b0;
            eclk_d2 <= 1'b0;
        end
        else
        begin
            eclk_d1 <= eclk;
            eclk_d2 <= eclk_d1;
        end
    end

    assign eclk_rise = eclk_d1 & ~eclk_d2;   // Low then high
    assign eclk_fall = ~eclk_d1 & eclk_d2;   // High then low

    // Every clk in continuous mode, else only on the chosen eclk edge
    assign capture = !ctrl.edge_sample ? 1'b1 :
                     (ctrl.sample_rising ? eclk_rise : eclk_fall);

    // ==================================================
    // Input capture
    // ==================================================
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            in_bits <= '0;
        else if (capture)
            in_bits <= pad_in;   // Holds between selected edges
    end

endmodule
